// ==== src/corr_pkg.sv ====
`default_nettype none

package corr_pkg;

	localparam int MAX_LAG_LOG = 3;
	localparam int NUM_TAPS = 1 << MAX_LAG_LOG; // Delay depth of each line.
	localparam int SEQ_BITS = 16;

	localparam logic [3:0] FRAME_HDR_TAG = 4'hA;

	// Register-select codes carried in an address byte.
	localparam logic [2:0] REG_AUTO_LAG = 3'd0;
	localparam logic [2:0] REG_CROSS_LAG = 3'd1;
	localparam logic [2:0] REG_FLAGS = 3'd2; // Bit 0 invert, bit 1 enable.
	localparam logic [2:0] REG_CONTROL = 3'd3; // Bit 0 integrate, bit 1 sequence clear.

	typedef struct packed {
		logic is_addr;
		logic [2:0] reg_sel;
		logic [3:0] channel;
	} cmd_addr_t;

	typedef struct packed {
		logic is_addr; // Zero for a data byte.
		logic [6:0] value;
	} cmd_data_t;

	// One command byte, read either as an address or as a data byte.
	typedef union packed {
		cmd_addr_t addr;
		cmd_data_t data;
	} cmd_byte_u;

	typedef struct packed {
		logic [MAX_LAG_LOG-1:0] auto_lag;
		logic [MAX_LAG_LOG-1:0] cross_lag;
		logic invert;
		logic enable;
	} chan_cfg_t;

endpackage

`default_nettype wire

// ==== src/corr_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module corr_regs import corr_pkg::*; #(
	parameter int NUM_INPUTS = 4
) (
	input wire logic intclk,
	input wire logic rst,
	input wire cmd_byte_u cmd_byte,
	input wire logic cmd_valid,
	output chan_cfg_t [NUM_INPUTS-1:0] cfg,
	output logic integrate_cmd,
	output logic seq_clear
);

	cmd_addr_t pend; // Last address byte seen.
	logic pend_valid;

	always_ff @(posedge intclk) begin
		if (rst) begin
			pend <= '0;
			pend_valid <= 1'b0;
			cfg <= '0;
			integrate_cmd <= 1'b0;
			seq_clear <= 1'b0;
		end else begin
			seq_clear <= 1'b0;
			if (cmd_valid) begin
				if (cmd_byte.addr.is_addr) begin
					pend <= cmd_byte.addr;
					pend_valid <= 1'b1;
				end else if (pend_valid) begin
					if (pend.reg_sel == REG_CONTROL) begin
						integrate_cmd <= cmd_byte.data.value[0];
						seq_clear <= cmd_byte.data.value[1];
					end else begin
						for (int c = 0; c < NUM_INPUTS; c++) begin
							if (pend.channel == 4'(c)) begin
								case (pend.reg_sel)
									REG_AUTO_LAG: cfg[c].auto_lag <= cmd_byte.data.value[MAX_LAG_LOG-1:0];
									REG_CROSS_LAG: cfg[c].cross_lag <= cmd_byte.data.value[MAX_LAG_LOG-1:0];
									REG_FLAGS: begin
										cfg[c].invert <= cmd_byte.data.value[0];
										cfg[c].enable <= cmd_byte.data.value[1];
									end
									default: ; // Unused select codes.
								endcase
							end
						end
					end
				end
			end
		end
	end

	// Channel registers exist only below NUM_INPUTS.
	a_channel_in_range: assert property (@(posedge intclk) disable iff (rst)
		(cmd_valid && cmd_byte.addr.is_addr && cmd_byte.addr.reg_sel != REG_CONTROL)
		|-> (int'(cmd_byte.addr.channel) < NUM_INPUTS));

endmodule

`default_nettype wire

// ==== src/tap_delay.sv ====
`timescale 1ns/1ps
`default_nettype none

module tap_delay import corr_pkg::*; #(
	parameter int NUM_INPUTS = 4
) (
	input wire logic intclk,
	input wire logic rst,
	input wire logic [NUM_INPUTS-1:0] line_in,
	input wire chan_cfg_t [NUM_INPUTS-1:0] cfg,
	output logic [NUM_INPUTS-1:0][NUM_TAPS-1:0] taps
);

	genvar a;

	generate
		for (a = 0; a < NUM_INPUTS; a++) begin : g_line
			always_ff @(posedge intclk) begin
				if (rst) begin
					taps[a] <= '0;
				end else begin
					// Tap 0 is the sample of this cycle, older ones move up.
					taps[a] <= {taps[a][NUM_TAPS-2:0], line_in[a] ^ cfg[a].invert};
				end
			end
		end
	endgenerate

endmodule

`default_nettype wire

// ==== src/corr_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module corr_counters import corr_pkg::*; #(
	parameter int NUM_INPUTS = 4,
	parameter int RESOLUTION = 16
) (
	input wire logic intclk,
	input wire logic rst,
	input wire logic [NUM_INPUTS-1:0][NUM_TAPS-1:0] taps,
	input wire chan_cfg_t [NUM_INPUTS-1:0] cfg,
	input wire logic integrating,
	input wire logic count_clear,
	output logic [NUM_INPUTS-1:0][2:0][RESOLUTION-1:0] count_bus,
	output logic [NUM_INPUTS-1:0] sat_flags
);

	genvar a;

	generate
		for (a = 0; a < NUM_INPUTS; a++) begin : g_chan
			localparam int NXT = (a + 1) % NUM_INPUTS; // Partner for the cross term.

			logic [2:0] hit; // Pulse, auto, cross.
			logic [2:0][RESOLUTION-1:0] cnt;
			logic sat;

			assign hit[0] = taps[a][0];
			assign hit[1] = taps[a][0] & taps[a][cfg[a].auto_lag];
			assign hit[2] = taps[a][0] & taps[NXT][cfg[a].cross_lag];

			always_ff @(posedge intclk) begin
				if (rst || count_clear) begin
					cnt <= '0;
					sat <= 1'b0;
				end else if (integrating && cfg[a].enable) begin
					for (int k = 0; k < 3; k++) begin
						if (hit[k]) begin
							if (cnt[k] == '1) begin
								sat <= 1'b1; // A count was lost.
							end else begin
								cnt[k] <= cnt[k] + 1'b1;
							end
						end
					end
				end
			end

			assign count_bus[a] = cnt;
			assign sat_flags[a] = sat;
		end
	endgenerate

	// The clear comes after the window has closed.
	a_clear_outside_window: assert property (@(posedge intclk) disable iff (rst)
		count_clear |-> !integrating);

endmodule

`default_nettype wire

// ==== src/frame_builder.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_builder import corr_pkg::*; #(
	parameter int NUM_INPUTS = 4,
	parameter int RESOLUTION = 16
) (
	input wire logic intclk,
	input wire logic rst,
	input wire logic strobe,
	input wire logic integrate_cmd,
	input wire logic seq_clear,
	input wire logic [NUM_INPUTS-1:0][2:0][RESOLUTION-1:0] count_bus,
	input wire logic [NUM_INPUTS-1:0] sat_flags,
	output logic integrating,
	output logic count_clear,
	output logic [RESOLUTION-1:0] word_out,
	output logic word_valid,
	output logic word_last
);

	localparam int FRAME_LEN = 1 + 3 * NUM_INPUTS;
	localparam int IDX_W = $clog2(FRAME_LEN);
	localparam int FLAG_W = (NUM_INPUTS < RESOLUTION - 4) ? NUM_INPUTS : RESOLUTION - 4;
	localparam int SEQ_ROOM = RESOLUTION - 4 - FLAG_W;
	localparam int SEQ_W = (SEQ_ROOM < SEQ_BITS) ? SEQ_ROOM : SEQ_BITS;

	logic win_prev;
	logic win_fall;
	logic busy;
	logic [IDX_W-1:0] idx;
	logic [SEQ_BITS-1:0] seq;
	logic [3*NUM_INPUTS-1:0][RESOLUTION-1:0] snap; // Channel-major, pulse first.
	logic [NUM_INPUTS-1:0] sat_snap;
	logic [RESOLUTION-1:0] hdr_word;

	assign win_fall = win_prev & ~integrating;

	always_ff @(posedge intclk) begin
		if (rst) begin
			integrating <= 1'b0;
			win_prev <= 1'b0;
			count_clear <= 1'b0;
			busy <= 1'b0;
			idx <= '0;
			seq <= '0;
		end else begin
			integrating <= strobe | integrate_cmd;
			win_prev <= integrating;
			count_clear <= win_fall;
			if (count_clear) begin
				busy <= 1'b1; // Header goes out next cycle.
				idx <= '0;
			end else if (busy) begin
				idx <= idx + 1'b1;
				if (word_last) busy <= 1'b0;
			end
			if (seq_clear) seq <= '0;
			else if (word_last) seq <= seq + 1'b1;
		end
	end

	always_ff @(posedge intclk) begin
		if (win_fall) begin
			snap <= count_bus;
			sat_snap <= sat_flags;
		end
	end

	// Tag on top, then flags, sequence number in what is left below.
	always_comb begin
		hdr_word = '0;
		hdr_word[RESOLUTION-1 -: 4] = FRAME_HDR_TAG;
		for (int i = 0; i < FLAG_W; i++) hdr_word[RESOLUTION-5-i] = sat_snap[NUM_INPUTS-1-i];
		for (int i = 0; i < SEQ_W; i++) hdr_word[i] = seq[i];
	end

	always_comb begin
		word_out = hdr_word;
		for (int j = 0; j < 3 * NUM_INPUTS; j++) begin
			if (idx == IDX_W'(j + 1)) word_out = snap[j];
		end
	end

	assign word_valid = busy;
	assign word_last = busy && (idx == IDX_W'(FRAME_LEN - 1));

	// No back-pressure, so a new window end would overwrite the snapshot.
	a_no_close_while_streaming: assert property (@(posedge intclk) disable iff (rst)
		win_fall |-> !(busy || count_clear));

endmodule

`default_nettype wire

// ==== src/correlator_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module correlator_top import corr_pkg::*; #(
	parameter int NUM_INPUTS = 4,
	parameter int RESOLUTION = 16
) (
	input wire logic intclk,
	input wire logic rst,
	input wire logic [NUM_INPUTS-1:0] line_in,
	input wire logic strobe,
	input wire logic [7:0] cmd_byte,
	input wire logic cmd_valid,
	output logic [RESOLUTION-1:0] word_out,
	output logic word_valid,
	output logic word_last,
	output logic integrating
);

	chan_cfg_t [NUM_INPUTS-1:0] cfg;
	logic integrate_cmd;
	logic seq_clear;
	logic [NUM_INPUTS-1:0][NUM_TAPS-1:0] taps;
	logic [NUM_INPUTS-1:0][2:0][RESOLUTION-1:0] count_bus;
	logic [NUM_INPUTS-1:0] sat_flags;
	logic count_clear;

	corr_regs #(.NUM_INPUTS(NUM_INPUTS)) i_regs (
		.intclk(intclk),
		.rst(rst),
		.cmd_byte(cmd_byte),
		.cmd_valid(cmd_valid),
		.cfg(cfg),
		.integrate_cmd(integrate_cmd),
		.seq_clear(seq_clear)
	);

	tap_delay #(.NUM_INPUTS(NUM_INPUTS)) i_taps (
		.intclk(intclk),
		.rst(rst),
		.line_in(line_in),
		.cfg(cfg),
		.taps(taps)
	);

	corr_counters #(.NUM_INPUTS(NUM_INPUTS), .RESOLUTION(RESOLUTION)) i_counters (
		.intclk(intclk),
		.rst(rst),
		.taps(taps),
		.cfg(cfg),
		.integrating(integrating),
		.count_clear(count_clear),
		.count_bus(count_bus),
		.sat_flags(sat_flags)
	);

	frame_builder #(.NUM_INPUTS(NUM_INPUTS), .RESOLUTION(RESOLUTION)) i_frame (
		.intclk(intclk),
		.rst(rst),
		.strobe(strobe),
		.integrate_cmd(integrate_cmd),
		.seq_clear(seq_clear),
		.count_bus(count_bus),
		.sat_flags(sat_flags),
		.integrating(integrating),
		.count_clear(count_clear),
		.word_out(word_out),
		.word_valid(word_valid),
		.word_last(word_last)
	);

endmodule

`default_nettype wire

// ==== testbench/corr_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module corr_checker #(
	parameter int RESOLUTION = 16
) (
	input wire logic intclk,
	input wire logic rst,
	input wire logic strobe,
	input wire logic [RESOLUTION-1:0] word_out,
	input wire logic word_valid,
	input wire logic word_last,
	input wire logic integrating
);

	logic [RESOLUTION-1:0] exp_q[$];
	logic [RESOLUTION-1:0] exp_w;
	logic rst_seen = 1'b0;
	logic strobe_seen = 1'b0;
	logic opened = 1'b0; // A strobe window has been seen since reset.
	int errors = 0;
	int frames = 0;
	int idx = 0; // Word position inside the current frame.

	task automatic expect_word(input logic [RESOLUTION-1:0] w);
		exp_q.push_back(w);
	endtask

	task automatic drop_expected();
		exp_q.delete();
		idx = 0;
	endtask

	// Inputs are sampled where the DUT samples them.
	always @(posedge intclk) begin
		rst_seen <= rst;
		strobe_seen <= strobe;
		if (rst) begin
			opened <= 1'b0;
		end else if (strobe) begin
			opened <= 1'b1;
		end
	end

	always @(negedge intclk) begin
		if (rst_seen && (word_valid || word_last || integrating)) begin
			$display("Outputs are not idle during reset at %0t", $time);
			errors++;
		end
		if (!rst_seen && !opened && integrating) begin
			$display("integrating went high before the first window at %0t", $time);
			errors++;
		end
		if (!rst_seen && strobe_seen && !integrating) begin
			$display("integrating stayed low after strobe at %0t", $time);
			errors++;
		end
		if (word_last && !word_valid) begin
			$display("word_last came without word_valid at %0t", $time);
			errors++;
		end
		if (word_valid) begin
			if (exp_q.size() == 0) begin
				$display("Unexpected frame word %h at %0t, index %0d", word_out, $time, idx);
				errors++;
			end else begin
				exp_w = exp_q.pop_front();
				if (word_out !== exp_w) begin
					$display("Mismatch at %0t: word %0d is %h, expected %h",
						$time, idx, word_out, exp_w);
					errors++;
				end
			end
			if (word_last) begin
				if (exp_q.size() != 0) begin
					$display("Frame ended after %0d words with %0d words still expected",
						idx + 1, exp_q.size());
					errors++;
					exp_q.delete();
				end
				frames++;
				idx = 0;
			end else begin
				idx++;
			end
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tb_correlator.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_correlator;

	localparam int NUM_INPUTS = 4;
	localparam int RESOLUTION = 16;
	localparam int FRAME_LEN = 1 + 3 * NUM_INPUTS;
	localparam string DATA_FILE = "testbench/corr_testdata.txt";

	logic intclk = 1'b0;
	logic rst;
	logic [NUM_INPUTS-1:0] line_in;
	logic strobe;
	logic [7:0] cmd_byte;
	logic cmd_valid;
	logic [RESOLUTION-1:0] word_out;
	logic word_valid;
	logic word_last;
	logic integrating;
	longint limit_cycles = 0;
	int tests = 0;
	int failed = 0;

	correlator_top #(.NUM_INPUTS(NUM_INPUTS), .RESOLUTION(RESOLUTION)) i_dut (.*);

	corr_checker #(.RESOLUTION(RESOLUTION)) i_check (.*);

	initial begin
		forever #50 intclk = ~intclk;
	end

	task automatic hold(input int n);
		repeat (n) @(negedge intclk);
	endtask

	task automatic await_frame(input logic [127:0] name, input int win, input int errs,
			input int frames);
		int waited;
		waited = 0;
		while (i_check.frames == frames && waited < win + 40) begin
			@(negedge intclk);
			waited++;
		end
		tests++;
		if (i_check.frames == frames) begin
			$display("Test %0s: no frame arrived within %0d cycles", name, win + 40);
			i_check.drop_expected();
			failed++;
		end else if (i_check.errors != errs) begin
			$display("Test %0s: failed", name);
			failed++;
		end else begin
			$display("Test %0s: passed", name);
		end
	endtask

	// One walk over the data file. A dry walk only adds up the cycles.
	task automatic run_file(input int fd, input bit dry, output longint cycles);
		logic [127:0] tok;
		logic [127:0] name;
		logic [1023:0] rest;
		logic [RESOLUTION-1:0] w;
		logic [7:0] addr;
		logic [7:0] data;
		logic [NUM_INPUTS-1:0] smp;
		logic stb;
		int n;
		int k;
		int reps;
		int win;
		int errs;
		int frames;
		cycles = 0;
		win = 0;
		errs = 0;
		frames = 0;
		name = '0;
		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok == 128'("#")) begin
				k = $fgets(rest, fd);
			end else if (tok == 128'("test")) begin
				k = $fscanf(fd, "%s", name);
				win = 0;
				errs = i_check.errors;
				frames = i_check.frames;
				for (int i = 0; i < FRAME_LEN; i++) begin
					k = $fscanf(fd, "%h", w);
					if (!dry) i_check.expect_word(w);
				end
			end else if (tok == 128'("wr")) begin
				k = $fscanf(fd, "%d", n);
				for (int i = 0; i < n; i++) begin
					k = $fscanf(fd, "%h %h", addr, data);
					cycles += 2;
					if (!dry) begin
						cmd_byte = addr; // Address byte, then data byte.
						cmd_valid = 1'b1;
						hold(1);
						cmd_byte = data;
						hold(1);
						cmd_valid = 1'b0;
					end
				end
			end else if (tok == 128'("smp")) begin
				k = $fscanf(fd, "%d", n);
				for (int i = 0; i < n; i++) begin
					k = $fscanf(fd, "%h %h %d", smp, stb, reps);
					cycles += reps;
					win += reps;
					if (!dry) begin
						line_in = smp;
						strobe = stb;
						hold(reps);
					end
				end
			end else if (tok == 128'("end")) begin
				cycles += FRAME_LEN;
				if (!dry) await_frame(name, win, errs, frames);
			end
		end
	endtask

	initial begin
		wait (limit_cycles != 0);
		#(limit_cycles * 100);
		$display("Watchdog expired after %0d cycles before the tests finished", limit_cycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		int fd;
		longint total;
		rst = 1'b1;
		line_in = '0;
		strobe = 1'b0;
		cmd_byte = '0;
		cmd_valid = 1'b0;
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file %0s", DATA_FILE);
			$display("SOME TESTS FAILED");
		end else begin
			run_file(fd, 1'b1, total);
			$fclose(fd);
			limit_cycles = total + 200;
			hold(5);
			rst = 1'b0;
			fd = $fopen(DATA_FILE, "r");
			run_file(fd, 1'b0, total);
			$fclose(fd);
			$display("%0d tests run, %0d failed, %0d check errors", tests, failed, i_check.errors);
			if (failed == 0 && i_check.errors == 0) begin
				$display("ALL TESTS PASSED");
			end else begin
				$display("SOME TESTS FAILED");
			end
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/corr_testdata.txt ====
# test <name> <13 expected frame words in hex> | wr <n> then n address and data byte pairs
# smp <n> then n groups of line_in (hex) strobe cycles | end waits for the frame of the test
test reset_idle A000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
smp 3 0 0 8 F 1 4 0 0 1
end
test pulse_lag0 A001 0003 0003 0002 0005 0005 0003 0004 0004 0003 0000 0000 0000
wr 3 A0 02 A1 02 A2 02
smp 5 0 0 8 3 1 2 5 1 1 E 1 3 0 0 1
end
test strobe_lags A002 0004 0001 0003 0005 0005 0003 0003 0003 0002 0004 0002 0002
wr 5 80 02 90 01 91 03 A3 02 83 01
smp 6 0 0 8 F 1 2 5 1 1 A 1 2 3 1 1 0 0 1
end
test cmd_window A003 0001 0000 0001 0002 0002 0000 0002 0002 0000 0001 0000 0001
wr 1 B0 01
smp 3 6 0 2 9 0 1 0 0 1
wr 1 B0 00
end
test invert A004 0001 0000 0000 0000 0000 0000 0001 0001 0000 0000 0000 0000
wr 1 A2 03
smp 4 4 0 8 4 1 2 1 1 1 4 0 1
end
test saturate AF05 FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
wr 1 A2 02
smp 3 F 0 8 F 1 65536 0 0 1
end
test seq_clear A000 0000 0000 0000 0001 0001 0000 0000 0000 0000 0000 0000 0000
wr 1 B0 02
smp 3 0 0 8 2 1 1 0 0 1
end

// ==== flist.f ====
src/corr_pkg.sv
src/corr_regs.sv
src/tap_delay.sv
src/corr_counters.sv
src/frame_builder.sv
src/correlator_top.sv
testbench/corr_checker.sv
testbench/tb_correlator.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_correlator
FLAGS ?= --timing --assert
FLIST ?= flist.f
PASS_MSG ?= ALL TESTS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
